// File: ddr_scrub_top.f
+incdir+source
source/scrub_pkg.sv
source/mem_bus_if.sv
source/scrub_regs.sv
source/line_scanner.sv
source/fault_log.sv
source/mem_arbiter.sv
source/ddr_scrub_top.sv
verif/tb_clk_gen.sv
verif/ddr_scrub_tb.sv

// File: source/ddr_scrub_top.sv
// DDR read scrubber top level with APB control and an external memory read bus
`timescale 1ns/1ps
`include "scrub_settings.svh"

module ddr_scrub_top (
   input  logic                        mem_clk90,
   input  logic                        mem_rst,
   // apb slave
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [7:0]                  paddr,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   // memory read bus
   output logic                        mem_req,
   output logic [`SCRUB_ADDR_BITS-1:0] mem_addr,
   output logic [`SCRUB_LEN_BITS-1:0]  mem_len,
   input  logic                        mem_grant,
   input  logic [`SCRUB_DATA_BITS-1:0] mem_rdata,
   input  logic                        mem_rvalid
);

   logic                           scan_enable;
   logic                           log_push;
   logic                           log_pop;
   logic [`SCRUB_ROW_BITS-1:0]     log_row;
   logic [`SCRUB_PASS_BITS-1:0]    pass_count;
   logic                           pass_overrun;
   logic                           log_head_valid;
   logic [`SCRUB_ROW_BITS-1:0]     log_head_row;
   logic [`SCRUB_LOG_CNT_BITS-1:0] log_count;
   logic                           log_overflow;

   mem_bus_if scan_bus ();
   mem_bus_if peek_bus ();

   scrub_regs u_regs (
      .mem_clk90      (mem_clk90),
      .mem_rst        (mem_rst),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .pass_count     (pass_count),
      .pass_overrun   (pass_overrun),
      .log_head_valid (log_head_valid),
      .log_head_row   (log_head_row),
      .log_count      (log_count),
      .log_overflow   (log_overflow),
      .scan_enable    (scan_enable),
      .log_pop        (log_pop),
      .bus            (peek_bus.requester)
   );

   line_scanner u_scanner (
      .mem_clk90    (mem_clk90),
      .mem_rst      (mem_rst),
      .scan_enable  (scan_enable),
      .log_push     (log_push),
      .log_row      (log_row),
      .pass_count   (pass_count),
      .pass_overrun (pass_overrun),
      .bus          (scan_bus.requester)
   );

   fault_log u_log (
      .mem_clk90  (mem_clk90),
      .mem_rst    (mem_rst),
      .push       (log_push),
      .push_row   (log_row),
      .pop        (log_pop),
      .head_valid (log_head_valid),
      .head_row   (log_head_row),
      .count      (log_count),
      .overflow   (log_overflow)
   );

   mem_arbiter u_arbiter (
      .mem_clk90  (mem_clk90),
      .mem_rst    (mem_rst),
      .mem_grant  (mem_grant),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .mem_req    (mem_req),
      .mem_addr   (mem_addr),
      .mem_len    (mem_len),
      .scan       (scan_bus.arbiter),
      .peek       (peek_bus.arbiter)
   );

endmodule

// File: source/fault_log.sv
// fault log FIFO of faulty row numbers with a sticky overflow flag
`timescale 1ns/1ps
`include "scrub_settings.svh"

module fault_log (
   input  logic                           mem_clk90,
   input  logic                           mem_rst,
   input  logic                           push,
   input  logic [`SCRUB_ROW_BITS-1:0]     push_row,
   input  logic                           pop,
   output logic                           head_valid,
   output logic [`SCRUB_ROW_BITS-1:0]     head_row,
   output logic [`SCRUB_LOG_CNT_BITS-1:0] count,
   output logic                           overflow
);

   localparam int DEPTH    = `SCRUB_LOG_DEPTH;
   localparam int PTR_BITS = $clog2(DEPTH);
   localparam int CNT_BITS = `SCRUB_LOG_CNT_BITS;

   logic [`SCRUB_ROW_BITS-1:0] entries [DEPTH];
   logic [PTR_BITS-1:0]        wr_ptr;
   logic [PTR_BITS-1:0]        rd_ptr;
   logic                       full;
   logic                       do_push;
   logic                       do_pop;

   function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
      return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full       = (count == CNT_BITS'(DEPTH));
   assign head_valid = (count != '0);
   assign head_row   = entries[rd_ptr];
   assign do_push    = push && !full;       // dropped when full
   assign do_pop     = pop && head_valid;

   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
         if (push && full)
            overflow <= 1'b1;
      end
   end

   always_ff @(posedge mem_clk90) begin
      if (do_push)
         entries[wr_ptr] <= push_row;
   end

   assert property (@(posedge mem_clk90) disable iff (mem_rst)
      count <= CNT_BITS'(DEPTH))
      else $error("fault log count above depth");

endmodule

// File: source/line_scanner.sv
// line scanner that reads every row of the region and flags lines off the fill word
`timescale 1ns/1ps
`include "scrub_settings.svh"

module line_scanner (
   input  logic                        mem_clk90,
   input  logic                        mem_rst,
   input  logic                        scan_enable,
   output logic                        log_push,
   output logic [`SCRUB_ROW_BITS-1:0]  log_row,
   output logic [`SCRUB_PASS_BITS-1:0] pass_count,
   output logic                        pass_overrun,
   mem_bus_if.requester                bus
);
   import scrub_pkg::*;

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_REQ  = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;

   localparam logic [`SCRUB_LEN_BITS-1:0] LINE_LEN = `SCRUB_LEN_BITS'(`SCRUB_LINE_WORDS);
   localparam logic [`SCRUB_ROW_BITS-1:0] ROW_LAST = `SCRUB_ROW_BITS'(`SCRUB_ROW_LAST);

   logic [1:0]                 state;
   logic [`SCRUB_ROW_BITS-1:0] row;
   logic [`SCRUB_LEN_BITS-1:0] word_cnt;
   logic                       line_fault;   // any mismatch so far in this line
   logic                       mismatch;
   logic                       line_end;
   mem_addr_u                  line_addr;

   // every line starts at column 0, bank 0
   always_comb begin
      line_addr       = '0;
      line_addr.f.row = row;
   end

   assign bus.addr = line_addr;
   assign bus.len  = LINE_LEN;

   assign mismatch = bus.rvalid && (bus.rdata != `SCRUB_FILL_WORD);
   assign line_end = (state == ST_DATA) && bus.rvalid && (word_cnt == LINE_LEN - 1'b1);

   // --------------------
   // line sequencer
   // --------------------

   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         state        <= ST_IDLE;
         bus.req      <= 1'b0;
         row          <= '0;
         word_cnt     <= '0;
         line_fault   <= 1'b0;
         log_push     <= 1'b0;
         pass_count   <= '0;
         pass_overrun <= 1'b0;
      end else begin
         log_push <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (scan_enable) begin   // fresh start always at row 0
                  row        <= '0;
                  line_fault <= 1'b0;
                  bus.req    <= 1'b1;
                  state      <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (bus.grant) begin
                  bus.req  <= 1'b0;
                  word_cnt <= '0;
                  state    <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (bus.rvalid) begin
                  word_cnt <= word_cnt + 1'b1;
                  if (mismatch)
                     line_fault <= 1'b1;
               end
               if (line_end) begin
                  log_push   <= line_fault || mismatch;
                  line_fault <= 1'b0;
                  if (row == ROW_LAST) begin
                     row        <= '0;
                     pass_count <= pass_count + 1'b1;
                     if (&pass_count)
                        pass_overrun <= 1'b1;   // sticky
                  end else begin
                     row <= row + 1'b1;
                  end
                  // a dropped enable lets the line finish, then idle
                  if (scan_enable) begin
                     bus.req <= 1'b1;
                     state   <= ST_REQ;
                  end else begin
                     state   <= ST_IDLE;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge mem_clk90) begin
      if (line_end)
         log_row <= row;
   end

   assert property (@(posedge mem_clk90) disable iff (mem_rst)
      bus.req && !bus.grant |=> $stable(bus.addr) && $stable(bus.len))
      else $error("scanner request changed before grant");

endmodule

// File: source/mem_arbiter.sv
// round robin arbiter handing the memory read bus to one burst at a time
`timescale 1ns/1ps
`include "scrub_settings.svh"

module mem_arbiter (
   input  logic                        mem_clk90,
   input  logic                        mem_rst,
   input  logic                        mem_grant,
   input  logic [`SCRUB_DATA_BITS-1:0] mem_rdata,
   input  logic                        mem_rvalid,
   output logic                        mem_req,
   output logic [`SCRUB_ADDR_BITS-1:0] mem_addr,
   output logic [`SCRUB_LEN_BITS-1:0]  mem_len,
   mem_bus_if.arbiter                  scan,
   mem_bus_if.arbiter                  peek
);
   import scrub_pkg::*;

   localparam int LEN_BITS = `SCRUB_LEN_BITS;

   logic                pending;      // forwarded, waiting for grant
   logic                in_burst;
   logic                owner;        // 0 scanner, 1 peek
   logic                last_owner;
   logic                pick;
   logic [LEN_BITS-1:0] remaining;
   mem_addr_u           sel_addr;

   // with both asking, the peer that did not own the last burst wins
   assign pick = (scan.req && peek.req) ? !last_owner : peek.req;

   assign sel_addr = owner ? peek.addr : scan.addr;
   assign mem_req  = pending;
   assign mem_addr = sel_addr.flat;
   assign mem_len  = owner ? peek.len : scan.len;

   assign scan.grant  = pending && mem_grant && !owner;
   assign peek.grant  = pending && mem_grant && owner;
   assign scan.rdata  = mem_rdata;
   assign peek.rdata  = mem_rdata;
   assign scan.rvalid = in_burst && mem_rvalid && !owner;
   assign peek.rvalid = in_burst && mem_rvalid && owner;

   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         pending    <= 1'b0;
         in_burst   <= 1'b0;
         owner      <= 1'b0;
         last_owner <= 1'b1;   // scanner first
         remaining  <= '0;
      end else if (pending) begin
         if (mem_grant) begin
            pending   <= 1'b0;
            in_burst  <= 1'b1;
            remaining <= mem_len;
         end
      end else if (in_burst) begin
         if (mem_rvalid) begin
            remaining <= remaining - 1'b1;
            if (remaining == LEN_BITS'(1)) begin   // last word of the burst
               in_burst   <= 1'b0;
               last_owner <= owner;
            end
         end
      end else if (scan.req || peek.req) begin
         owner   <= pick;
         pending <= 1'b1;
      end
   end

   assert property (@(posedge mem_clk90) disable iff (mem_rst)
      !(scan.grant && peek.grant))
      else $error("both requesters granted in one cycle");

endmodule

// File: source/mem_bus_if.sv
// read channel between one requester and the memory arbiter
`timescale 1ns/1ps
`include "scrub_settings.svh"

interface mem_bus_if;
   import scrub_pkg::*;

   logic                        req;
   mem_addr_u                   addr;
   logic [`SCRUB_LEN_BITS-1:0]  len;
   logic                        grant;    // one cycle, from the memory
   logic [`SCRUB_DATA_BITS-1:0] rdata;
   logic                        rvalid;   // only for the burst owner

   modport requester (
      output req, addr, len,
      input  grant, rdata, rvalid
   );

   modport arbiter (
      input  req, addr, len,
      output grant, rdata, rvalid
   );

endinterface

// File: source/scrub_pkg.sv
// shared types of the DDR read scrubber, the memory address and the register map
`include "scrub_settings.svh"

package scrub_pkg;

   // --------------------
   // memory address
   // --------------------

   // the bus carries one flat word, the scanner and peek build it from fields
   typedef union packed {
      logic [`SCRUB_ADDR_BITS-1:0] flat;
      struct packed {
         logic [`SCRUB_ROW_BITS-1:0]  row;    // top bits
         logic [`SCRUB_COL_BITS-1:0]  col;
         logic [`SCRUB_BANK_BITS-1:0] bank;   // low bits
      } f;
   } mem_addr_u;

   // --------------------
   // apb registers
   // --------------------

   typedef enum logic [7:0] {
      REG_CTRL      = `SCRUB_REG_CTRL,        // bit 0 enable
      REG_STATUS    = `SCRUB_REG_STATUS,      // passes, overrun, log state, peek busy
      REG_FAULT_POP = `SCRUB_REG_FAULT_POP,   // read pops one row
      REG_PEEK_ADDR = `SCRUB_REG_PEEK_ADDR,   // write starts a peek
      REG_PEEK_DATA = `SCRUB_REG_PEEK_DATA
   } reg_offset_e;

endpackage

// File: source/scrub_regs.sv
// APB register block with scan control, fault log pop and single word peek
`timescale 1ns/1ps
`include "scrub_settings.svh"

module scrub_regs (
   input  logic                           mem_clk90,
   input  logic                           mem_rst,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [7:0]                     paddr,
   input  logic [31:0]                    pwdata,
   output logic [31:0]                    prdata,
   output logic                           pready,
   output logic                           pslverr,
   input  logic [`SCRUB_PASS_BITS-1:0]    pass_count,
   input  logic                           pass_overrun,
   input  logic                           log_head_valid,
   input  logic [`SCRUB_ROW_BITS-1:0]     log_head_row,
   input  logic [`SCRUB_LOG_CNT_BITS-1:0] log_count,
   input  logic                           log_overflow,
   output logic                           scan_enable,
   output logic                           log_pop,
   mem_bus_if.requester                   bus
);
   import scrub_pkg::*;

   logic                        wr_access;
   logic                        rd_access;
   logic                        mapped;
   logic                        peek_start;
   logic                        peek_busy;
   mem_addr_u                   peek_addr;
   logic [`SCRUB_DATA_BITS-1:0] peek_data;

   assign wr_access = psel && penable && pwrite;
   assign rd_access = psel && penable && !pwrite;

   // --------------------
   // apb decode
   // --------------------

   assign pready  = 1'b1;   // no wait states
   assign pslverr = psel && penable && !mapped;

   always_comb begin
      mapped = 1'b1;
      prdata = '0;
      case (paddr)
         REG_CTRL:      prdata = {31'd0, scan_enable};
         REG_STATUS:    prdata = {9'd0, peek_busy, 4'(log_count), log_overflow,
                                  pass_overrun, pass_count};
         REG_FAULT_POP: prdata = {log_head_valid, {(31 - `SCRUB_ROW_BITS){1'b0}},
                                  log_head_row};
         REG_PEEK_ADDR: prdata = {{(32 - `SCRUB_ADDR_BITS){1'b0}}, peek_addr.flat};
         REG_PEEK_DATA: prdata = peek_data;
         default:       mapped = 1'b0;
      endcase
   end

   // head entry shows in prdata this cycle, leaves the log at the edge
   assign log_pop = rd_access && (paddr == REG_FAULT_POP) && log_head_valid;

   // --------------------
   // control and peek
   // --------------------

   assign peek_start = wr_access && (paddr == REG_PEEK_ADDR) && !peek_busy;
   assign bus.addr   = peek_addr;
   assign bus.len    = `SCRUB_LEN_BITS'(1);   // single word

   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         scan_enable <= 1'b0;
         peek_busy   <= 1'b0;
         bus.req     <= 1'b0;
      end else begin
         if (wr_access && (paddr == REG_CTRL))
            scan_enable <= pwdata[0];
         if (peek_start) begin
            peek_busy <= 1'b1;
            bus.req   <= 1'b1;
         end else if (bus.grant) begin
            bus.req   <= 1'b0;
         end
         if (peek_busy && bus.rvalid)
            peek_busy <= 1'b0;   // word has landed
      end
   end

   always_ff @(posedge mem_clk90) begin
      if (peek_start)
         peek_addr.flat <= pwdata[`SCRUB_ADDR_BITS-1:0];
      if (peek_busy && bus.rvalid)
         peek_data <= bus.rdata;
   end

   // once granted, the peek stays off the bus until its word lands
   assert property (@(posedge mem_clk90) disable iff (mem_rst)
      peek_busy && !bus.req |-> !bus.grant)
      else $error("second peek request granted while a peek was in flight");

endmodule

// File: source/scrub_settings.svh
// build settings for the DDR read scrubber widths, sizes and register map
`ifndef SCRUB_SETTINGS_SVH
`define SCRUB_SETTINGS_SVH

// memory address layout, row on top and bank at the bottom
`define SCRUB_ROW_BITS     13
`define SCRUB_COL_BITS     10
`define SCRUB_BANK_BITS    2
`define SCRUB_ADDR_BITS    25     // row + col + bank
`define SCRUB_DATA_BITS    32
`define SCRUB_LEN_BITS     10     // burst length field

// scan region, kept small for simulation
`define SCRUB_LINE_WORDS   16
`define SCRUB_ROW_LAST     7      // 8 rows per pass
`define SCRUB_FILL_WORD    32'hFDCB_8610

`define SCRUB_LOG_DEPTH    4
`define SCRUB_LOG_CNT_BITS $clog2(`SCRUB_LOG_DEPTH + 1)
`define SCRUB_PASS_BITS    16

// apb register offsets
`define SCRUB_REG_CTRL      8'h00
`define SCRUB_REG_STATUS    8'h04
`define SCRUB_REG_FAULT_POP 8'h08
`define SCRUB_REG_PEEK_ADDR 8'h0C
`define SCRUB_REG_PEEK_DATA 8'h10

`endif

// File: verif/ddr_scrub_tb.sv
// testbench for the DDR read scrubber with APB driver, memory model and checks
`timescale 1ns/1ps
`include "scrub_settings.svh"

module ddr_scrub_tb;
   import scrub_pkg::*;

   localparam int          PAT_WORDS = 64;
   localparam int          ROW_COUNT = `SCRUB_ROW_LAST + 1;
   localparam logic [31:0] SEED      = 32'hbcdc_93e7;

   logic                        mem_clk90;
   logic                        mem_rst;
   logic                        psel;
   logic                        penable;
   logic                        pwrite;
   logic [7:0]                  paddr;
   logic [31:0]                 pwdata;
   logic [31:0]                 prdata;
   logic                        pready;
   logic                        pslverr;
   logic                        mem_req;
   logic [`SCRUB_ADDR_BITS-1:0] mem_addr;
   logic [`SCRUB_LEN_BITS-1:0]  mem_len;
   logic                        mem_grant;
   logic [`SCRUB_DATA_BITS-1:0] mem_rdata;
   logic                        mem_rvalid;

   logic [31:0] patterns [PAT_WORDS];
   int          set_a_row[$];
   int          set_a_col[$];
   int          set_b_row[$];
   int          set_b_col[$];
   logic [31:0] peek_list[$];
   int          extra_passes;
   int          bad_row[$];     // corrupt words the model serves right now
   int          bad_col[$];
   int          exp_rows[$];
   logic        model_busy;
   logic        peek_wanted;    // a peek is outstanding at peek_target
   logic [31:0] peek_target;
   int          errors      = 0;
   int          checks      = 0;
   int          cycles      = 0;
   int          cycle_limit = 1000000;

   tb_clk_gen clk_gen (.mem_clk90(mem_clk90), .mem_rst(mem_rst));

   ddr_scrub_top uut (
      .mem_clk90  (mem_clk90),
      .mem_rst    (mem_rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .mem_req    (mem_req),
      .mem_addr   (mem_addr),
      .mem_len    (mem_len),
      .mem_grant  (mem_grant),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid)
   );

   // --------------------
   // helpers
   // --------------------

   function automatic logic [31:0] model_word(input int row, input int col);
      logic [31:0] word;
      word = `SCRUB_FILL_WORD;
      foreach (bad_row[i])
         if (bad_row[i] == row && bad_col[i] == col)
            word = ~(`SCRUB_FILL_WORD);   // corrupt cell reads inverted
      return word;
   endfunction

   function automatic bit is_mapped(input logic [7:0] addr);
      case (addr)
         REG_CTRL, REG_STATUS, REG_FAULT_POP, REG_PEEK_ADDR, REG_PEEK_DATA: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   task automatic flag_error(input string msg);
      errors++;
      $display("** Error at %0t ns: %s", $time, msg);
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
         else flag_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   // one APB transfer, inputs move 1 ns after the edge
   task automatic apb_access(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      logic err;
      @(posedge mem_clk90);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge mem_clk90);
      #1;
      penable = 1'b1;
      #1;                      // access phase, outputs settled
      rdata = prdata;
      err   = pslverr;
      checks++;
      assert (err === !is_mapped(addr))
         else flag_error($sformatf("pslverr %b at offset %h", err, addr));
      checks++;
      assert (pready === 1'b1)
         else flag_error($sformatf("pready %b at offset %h", pready, addr));
      @(posedge mem_clk90);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_access(1'b1, addr, data, unused);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      apb_access(1'b0, addr, '0, data);
   endtask

   task automatic wait_passes(input int target);
      logic [31:0] status;
      status = '0;
      while (status[15:0] < target)
         apb_read(REG_STATUS, status);
   endtask

   task automatic wait_bus_idle();
      int quiet;
      quiet = 0;
      while (quiet < 64) begin
         @(posedge mem_clk90);
         #2;
         if (mem_req || model_busy)
            quiet = 0;
         else
            quiet++;
      end
   endtask

   // distinct bad rows of the served set, in scan order
   task automatic collect_rows(input int limit);
      bit hit;
      exp_rows.delete();
      for (int r = 0; r < ROW_COUNT; r++) begin
         hit = 1'b0;
         foreach (bad_row[i])
            if (bad_row[i] == r)
               hit = 1'b1;
         if (hit && exp_rows.size() < limit)
            exp_rows.push_back(r);
      end
   endtask

   task automatic pop_and_check();
      logic [31:0] data;
      foreach (exp_rows[i]) begin
         apb_read(REG_FAULT_POP, data);
         check_value($sformatf("fault pop %0d", i), data, {1'b1, 31'(exp_rows[i])});
      end
      apb_read(REG_FAULT_POP, data);
      check_value("pop of empty log", {data[31], 31'd0}, 32'd0);
   endtask

   task automatic peek_and_check(input logic [31:0] addr);
      mem_addr_u   a;
      logic [31:0] data;
      a.flat      = addr[`SCRUB_ADDR_BITS-1:0];
      peek_target = addr;
      peek_wanted = 1'b1;
      apb_write(REG_PEEK_ADDR, addr);
      data = 32'h0040_0000;
      while (data[22])         // peek busy
         apb_read(REG_STATUS, data);
      peek_wanted = 1'b0;
      apb_read(REG_PEEK_DATA, data);
      check_value($sformatf("peek at %h", addr), data, model_word(a.f.row, a.f.col));
   endtask

   task automatic load_patterns();
      foreach (patterns[i])
         patterns[i] = '0;
      $readmemh("verif/scrub_patterns.txt", patterns);
      foreach (patterns[i]) begin
         case (patterns[i][31:28])
            4'h1: begin
               set_a_row.push_back(patterns[i][27:16]);
               set_a_col.push_back(patterns[i][15:0]);
            end
            4'h2: begin
               set_b_row.push_back(patterns[i][27:16]);
               set_b_col.push_back(patterns[i][15:0]);
            end
            4'h3: peek_list.push_back({7'd0, patterns[i][24:0]});
            4'h4: extra_passes = patterns[i][15:0];
            default: ;
         endcase
      end
   endtask

   // --------------------
   // memory model
   // --------------------

   initial begin : memory_model
      mem_addr_u a;
      int        len;
      int        exp_len;
      mem_grant  = 1'b0;
      mem_rvalid = 1'b0;
      mem_rdata  = '0;
      model_busy = 1'b0;
      void'($urandom(SEED));
      forever begin
         @(posedge mem_clk90);
         #1;
         if (!mem_rst && mem_req) begin
            model_busy = 1'b1;
            a.flat     = mem_addr;
            len        = mem_len;
            // a peek asks for one word, a line scan for a whole line
            if (peek_wanted && mem_addr === peek_target[`SCRUB_ADDR_BITS-1:0])
               exp_len = 1;
            else
               exp_len = `SCRUB_LINE_WORDS;
            checks++;
            assert (len == exp_len)
               else flag_error($sformatf("burst length %0d at %h, expected %0d",
                                         len, a.flat, exp_len));
            repeat ($urandom % 3 + 1) begin
               @(posedge mem_clk90);
               #1;
            end
            checks++;
            assert (mem_req === 1'b1 && mem_addr === a.flat && mem_len === len)
               else flag_error("memory request dropped or changed before grant");
            mem_grant = 1'b1;
            @(posedge mem_clk90);
            #1;
            mem_grant = 1'b0;
            checks++;
            assert (mem_req === 1'b0)
               else flag_error($sformatf("mem_req %b in the cycle after grant", mem_req));
            for (int i = 0; i < len; i++) begin
               while ($urandom % 4 == 0) begin   // random gap
                  @(posedge mem_clk90);
                  #1;
               end
               mem_rvalid = 1'b1;
               mem_rdata  = model_word(a.f.row, a.f.col + i);
               @(posedge mem_clk90);
               #1;
               mem_rvalid = 1'b0;
            end
            model_busy = 1'b0;
         end
      end
   end

   always @(posedge mem_clk90) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // --------------------
   // test sequence
   // --------------------

   initial begin : main
      logic [31:0] data;
      logic [31:0] snap [4];
      int          target;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      peek_wanted = 1'b0;
      peek_target = '0;
      load_patterns();
      if (peek_list.size() == 0 || extra_passes == 0) begin
         errors++;
         $display("stimulus file verif/scrub_patterns.txt missing or incomplete");
      end
      target      = 1 + extra_passes;
      cycle_limit = target * ROW_COUNT * (`SCRUB_LINE_WORDS * 4 + 8) + 2000;
      wait (mem_rst === 1'b0);

      // reset state
      check_value("mem_req after reset", {31'd0, mem_req}, 32'd0);
      apb_read(REG_STATUS, data);
      check_value("status after reset", data, 32'd0);
      apb_read(REG_FAULT_POP, data);
      check_value("pop after reset", {data[31], 31'd0}, 32'd0);

      // one pass, then the log holds each bad row once
      bad_row = set_a_row;
      bad_col = set_a_col;
      apb_write(REG_CTRL, 32'd1);
      wait_passes(1);
      apb_write(REG_CTRL, 32'd0);
      wait_bus_idle();
      collect_rows(`SCRUB_LOG_DEPTH);
      apb_read(REG_STATUS, data);
      check_value("status after one pass", data, {10'd0, 4'(exp_rows.size()), 2'b00, 16'd1});
      pop_and_check();

      // several passes with peeks, more bad rows than the log holds
      bad_row = set_b_row;
      bad_col = set_b_col;
      apb_write(REG_CTRL, 32'd1);
      foreach (peek_list[i])
         peek_and_check(peek_list[i]);
      wait_passes(target);
      apb_write(REG_CTRL, 32'd0);
      wait_bus_idle();
      apb_read(REG_STATUS, data);
      check_value("status after overflow run", data,
                  {10'd0, 4'(`SCRUB_LOG_DEPTH), 2'b10, 16'(target)});
      repeat (100) @(posedge mem_clk90);
      apb_read(REG_STATUS, data);
      check_value("pass count once idle", {16'd0, data[15:0]}, 32'(target));
      collect_rows(`SCRUB_LOG_DEPTH);
      pop_and_check();

      // unmapped offsets leave every register alone
      apb_read(REG_CTRL, snap[0]);
      apb_read(REG_STATUS, snap[1]);
      apb_read(REG_PEEK_ADDR, snap[2]);
      apb_read(REG_PEEK_DATA, snap[3]);
      apb_write(8'h14, 32'hffff_ffff);
      apb_write(8'h01, 32'h0000_0001);
      apb_read(8'h40, data);
      apb_read(REG_CTRL, data);
      check_value("ctrl after unmapped access", data, snap[0]);
      apb_read(REG_STATUS, data);
      check_value("status after unmapped access", data, snap[1]);
      apb_read(REG_PEEK_ADDR, data);
      check_value("peek addr after unmapped access", data, snap[2]);
      apb_read(REG_PEEK_DATA, data);
      check_value("peek data after unmapped access", data, snap[3]);

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: verif/scrub_patterns.txt
// tag in [31:28]: 1 bad word for the one pass test, 2 bad word for the overflow test
// bad words hold row in [27:16] and column in [15:0]; tag 3 is a peek address in [24:0]
// tag 4 is the number of passes in the overflow test
// one pass test, row 2 has two bad columns
1002_0003
1002_000b
1005_0000
1007_000f
// overflow test, five faulty rows
2000_0004
2001_0001
2003_0002
2004_0007
2006_0009
2006_000a
// peeks during the overflow test, the first two hit bad words
3000_6024
3000_300b
3000_301d
3010_0000
4000_0003

// File: verif/tb_clk_gen.sv
// testbench clock and reset source, 4 ns clock and a two cycle reset
`timescale 1ns/1ps

module tb_clk_gen (
   output logic mem_clk90,
   output logic mem_rst
);

   initial begin
      mem_clk90 = 1'b0;
      forever #2 mem_clk90 = ~mem_clk90;   // 4 ns period
   end

   initial begin
      mem_rst = 1'b1;
      repeat (2) @(posedge mem_clk90);
      #1;
      mem_rst = 1'b0;
   end

endmodule
